// File: files.f
asic_bus_pkg.sv
video_regs_pkg.sv
reg_write_if.sv
cpu_bus_decoder.sv
gate_array_regs.sv
crtc_regs.sv
acid_unlock.sv
asic_regs_top.sv
tb_asic_regs.sv

// File: Makefile
TOP = tb_asic_regs

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// File: tb_asic_regs.sv
`timescale 1ns/1ps
`default_nettype none

module tb_asic_regs;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 3;
    localparam int RD_TIMEOUT   = 8;   // Cycles allowed for rd_valid
    localparam int UNLOCK_WAIT  = 8;   // Cycles allowed for acid_unlocked
    // About 77 writes and 6 reads in all tests, at most 4 cycles per write
    localparam int NUM_WRITES   = 80;
    localparam int NUM_READS    = 10;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_WRITES * 4
                                   + NUM_READS * (2 + RD_TIMEOUT) + UNLOCK_WAIT + 200;

    logic                        clk_sys = 1'b0;
    logic                        reset;
    asic_bus_pkg::addr_t         cpu_addr;
    asic_bus_pkg::data_t         cpu_data_in;
    logic                        cpu_wr;
    logic                        cpu_rd;
    asic_bus_pkg::data_t         rd_data;
    logic                        rd_valid;
    asic_bus_pkg::data_t         ram_config;
    asic_bus_pkg::data_t         mrer;
    asic_bus_pkg::data_t         rom_select;
    video_regs_pkg::pen_t        current_pen;
    video_regs_pkg::ink_t        pen_ink;
    video_regs_pkg::crtc_index_t crtc_reg_select;
    logic                        acid_unlocked;

    // Expected state
    logic [4:0] ink_model [32];
    logic [7:0] crtc_model [32];
    logic       unlocked_model;
    int         errors;
    int         tests_run;
    int         tests_failed;

    logic [7:0] unlock_seq [16] = '{
        8'haa, 8'h00, 8'hff, 8'h77, 8'hb3, 8'h51, 8'ha8, 8'hd4,
        8'h62, 8'h39, 8'h9c, 8'h46, 8'h2b, 8'h15, 8'h8a, 8'hcd
    };

    asic_regs_top UUT (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .cpu_addr        (cpu_addr),
        .cpu_data_in     (cpu_data_in),
        .cpu_wr          (cpu_wr),
        .cpu_rd          (cpu_rd),
        .rd_data         (rd_data),
        .rd_valid        (rd_valid),
        .ram_config      (ram_config),
        .mrer            (mrer),
        .rom_select      (rom_select),
        .current_pen     (current_pen),
        .pen_ink         (pen_ink),
        .crtc_reg_select (crtc_reg_select),
        .acid_unlocked   (acid_unlocked)
    );

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    function automatic asic_bus_pkg::data_t random_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    function automatic asic_bus_pkg::addr_t ga_address(asic_bus_pkg::data_t offset);
        return {asic_bus_pkg::GA_PORT_HI, offset};
    endfunction

    task automatic compare(string test_name, string what, logic [31:0] expected,
                           logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    // One-cycle strobe, one idle cycle, returns with the target register settled
    task automatic bus_write(asic_bus_pkg::addr_t addr, asic_bus_pkg::data_t data);
        @(posedge clk_sys);
        cpu_addr    <= addr;
        cpu_data_in <= data;
        cpu_wr      <= 1'b1;
        @(posedge clk_sys);
        cpu_wr <= 1'b0;
        @(posedge clk_sys);  // Register updates here
        @(negedge clk_sys);
    endtask

    task automatic bus_read(string test_name, output asic_bus_pkg::data_t data);
        int waited;
        @(posedge clk_sys);
        cpu_addr <= asic_bus_pkg::CRTC_READ_ADDR;
        cpu_rd   <= 1'b1;
        @(posedge clk_sys);
        cpu_rd <= 1'b0;
        waited = 0;
        @(negedge clk_sys);
        while (!rd_valid && waited < RD_TIMEOUT) begin
            @(negedge clk_sys);
            waited++;
        end
        if (rd_valid) begin
            data = rd_data;
        end else begin
            $display("%s: no rd_valid came back for a read of BF00", test_name);
            errors++;
            data = 'x;
        end
    endtask

    task automatic finish_test(string test_name, int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: passed", test_name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, errors - errors_before);
        end
    endtask

    task automatic crtc_write_read(string test_name, asic_bus_pkg::data_t idx_byte,
                                   asic_bus_pkg::data_t value);
        int                  idx;
        asic_bus_pkg::data_t got;
        idx = idx_byte[4:0];
        bus_write(asic_bus_pkg::CRTC_SELECT_ADDR, idx_byte);
        compare(test_name, "crtc_reg_select", idx, crtc_reg_select);
        bus_write(asic_bus_pkg::CRTC_DATA_ADDR, value);
        if (idx < 16 || unlocked_model) begin
            crtc_model[idx] = value;  // Locked upper registers ignore data
        end
        bus_read(test_name, got);
        compare(test_name, "rd_data", crtc_model[idx], got);
    endtask

    task automatic pen_round(string test_name, asic_bus_pkg::data_t offset);
        logic [4:0]          pen;
        logic [4:0]          other;
        asic_bus_pkg::data_t rb;
        asic_bus_pkg::data_t ink_byte;
        rb = random_byte();
        pen = rb[4:0];
        rb = random_byte();
        ink_byte = {2'b11, rb[5:0]};
        bus_write(ga_address(offset), {3'b000, pen});
        compare(test_name, "current_pen", pen, current_pen);
        bus_write(ga_address(offset), ink_byte);
        ink_model[pen] = ink_byte[4:0];
        compare(test_name, "pen_ink", ink_model[pen], pen_ink);
        other = pen + 5'd1;
        bus_write(ga_address(offset), {3'b000, other});
        compare(test_name, "pen_ink other pen", ink_model[other], pen_ink);
        bus_write(ga_address(offset), {3'b000, pen});  // Back to the first pen
        compare(test_name, "pen_ink reselected", ink_model[pen], pen_ink);
    endtask

    task automatic reset_state();
        int err0;
        err0 = errors;
        compare("reset", "ram_config", 0, ram_config);
        compare("reset", "mrer", 0, mrer);
        compare("reset", "rom_select", 0, rom_select);
        compare("reset", "current_pen", 0, current_pen);
        compare("reset", "pen_ink", 0, pen_ink);
        compare("reset", "crtc_reg_select", 0, crtc_reg_select);
        compare("reset", "acid_unlocked", 0, acid_unlocked);
        compare("reset", "rd_data", 0, rd_data);
        repeat (4) begin
            @(negedge clk_sys);
            compare("reset", "rd_valid idle", 0, rd_valid);
        end
        finish_test("reset", err0);
    endtask

    task automatic pen_and_ink();
        int                  err0;
        asic_bus_pkg::data_t rb;
        err0 = errors;
        repeat (4) begin
            rb = random_byte();
            pen_round("pen_ink", {4'h0, rb[3:0]});
        end
        pen_round("pen_ink", 8'h10);
        finish_test("pen_ink", err0);
    endtask

    task automatic memory_config();
        int                  err0;
        asic_bus_pkg::data_t d;
        asic_bus_pkg::data_t mrer_expected;
        err0 = errors;
        for (int o = 0; o < 8; o++) begin
            bus_write(ga_address(asic_bus_pkg::RAM_CONFIG_BASE + 8'(o)), random_byte());
            compare("memory_config", "ram_config", asic_bus_pkg::RAM_CONFIG_BASE + o,
                    ram_config);
        end
        d = random_byte();
        bus_write(ga_address(asic_bus_pkg::MRER_OFFSET), d);
        compare("memory_config", "mrer via 89", d, mrer);
        mrer_expected = random_byte() | 8'h80;
        bus_write(ga_address(asic_bus_pkg::PAGING_OFFSET), mrer_expected);
        compare("memory_config", "mrer via B8", mrer_expected, mrer);
        d = random_byte() & 8'h7f;  // Bit 7 clear must leave MRER alone
        bus_write(ga_address(asic_bus_pkg::PAGING_OFFSET), d);
        compare("memory_config", "mrer kept", mrer_expected, mrer);
        d = random_byte();
        bus_write(asic_bus_pkg::ROM_SELECT_ADDR, d);
        compare("memory_config", "rom_select", d, rom_select);
        finish_test("memory_config", err0);
    endtask

    task automatic locked_crtc();
        int                  err0;
        asic_bus_pkg::data_t rb;
        err0 = errors;
        repeat (4) begin
            rb = random_byte();
            crtc_write_read("crtc_locked", {4'h0, rb[3:0]}, random_byte());
        end
        rb = random_byte();
        crtc_write_read("crtc_locked", {4'h1, rb[3:0]}, random_byte());  // Index 16 to 31
        finish_test("crtc_locked", err0);
    endtask

    task automatic unlock_sequence();
        int err0;
        int waited;
        err0 = errors;
        for (int i = 0; i < 10; i++) begin
            bus_write(asic_bus_pkg::CRTC_SELECT_ADDR, unlock_seq[i]);
        end
        bus_write(asic_bus_pkg::CRTC_SELECT_ADDR, 8'h01);  // Breaks the sequence
        // The count restarted, so the remaining six bytes alone must not unlock
        for (int i = 10; i < 16; i++) begin
            bus_write(asic_bus_pkg::CRTC_SELECT_ADDR, unlock_seq[i]);
        end
        repeat (3) @(negedge clk_sys);
        compare("unlock", "acid_unlocked after wrong byte", 0, acid_unlocked);
        for (int i = 0; i < 16; i++) begin
            bus_write(asic_bus_pkg::CRTC_SELECT_ADDR, unlock_seq[i]);
        end
        waited = 0;
        while (!acid_unlocked && waited < UNLOCK_WAIT) begin
            @(negedge clk_sys);
            waited++;
        end
        if (!acid_unlocked) begin
            $display("unlock: acid_unlocked never rose after the full sequence");
            errors++;
        end
        unlocked_model = 1'b1;
        crtc_write_read("unlock", 8'd20, random_byte());
        finish_test("unlock", err0);
    endtask

    task automatic held_write();
        int err0;
        err0 = errors;
        @(posedge clk_sys);
        cpu_addr    <= ga_address(8'hC0);
        cpu_data_in <= random_byte();
        cpu_wr      <= 1'b1;
        @(posedge clk_sys);
        cpu_addr    <= ga_address(8'hC5);  // Changes while the strobe stays high
        cpu_data_in <= random_byte();
        repeat (2) @(posedge clk_sys);
        @(posedge clk_sys);
        cpu_wr <= 1'b0;
        @(posedge clk_sys);
        @(negedge clk_sys);
        compare("held_write", "ram_config", 8'hC0, ram_config);
        finish_test("held_write", err0);
    endtask

    initial begin
        void'($urandom(1843));
        reset          = 1'b1;
        cpu_addr       = '0;
        cpu_data_in    = '0;
        cpu_wr         = 1'b0;
        cpu_rd         = 1'b0;
        unlocked_model = 1'b0;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        for (int i = 0; i < 32; i++) begin
            ink_model[i]  = '0;
            crtc_model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk_sys);
        reset <= 1'b0;
        @(negedge clk_sys);

        reset_state();
        pen_and_ink();
        memory_config();
        locked_crtc();
        unlock_sequence();
        held_write();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: asic_regs_top.sv
`timescale 1ns/1ps
`default_nettype none

module asic_regs_top (
    input  wire logic                   clk_sys,
    input  wire logic                   reset,
    input  wire asic_bus_pkg::addr_t    cpu_addr,
    input  wire asic_bus_pkg::data_t    cpu_data_in,
    input  wire logic                   cpu_wr,
    input  wire logic                   cpu_rd,
    output asic_bus_pkg::data_t         rd_data,
    output logic                        rd_valid,
    output asic_bus_pkg::data_t         ram_config,
    output asic_bus_pkg::data_t         mrer,
    output asic_bus_pkg::data_t         rom_select,
    output video_regs_pkg::pen_t        current_pen,
    output video_regs_pkg::ink_t        pen_ink,
    output video_regs_pkg::crtc_index_t crtc_reg_select,
    output logic                        acid_unlocked
);

    asic_bus_pkg::data_t selected_data;
    asic_bus_pkg::data_t select_byte;
    logic                crtc_select_wr;

    reg_write_if wr_bus ();

    cpu_bus_decoder u_decoder (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .cpu_addr      (cpu_addr),
        .cpu_data_in   (cpu_data_in),
        .cpu_wr        (cpu_wr),
        .cpu_rd        (cpu_rd),
        .selected_data (selected_data),
        .wr            (wr_bus.source),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid)
    );

    gate_array_regs u_gate_array (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .wr          (wr_bus.sink),
        .current_pen (current_pen),
        .pen_ink     (pen_ink),
        .ram_config  (ram_config),
        .mrer        (mrer),
        .rom_select  (rom_select)
    );

    crtc_regs u_crtc (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .wr              (wr_bus.sink),
        .unlocked        (acid_unlocked),
        .crtc_select_wr  (crtc_select_wr),
        .select_byte     (select_byte),
        .crtc_reg_select (crtc_reg_select),
        .selected_data   (selected_data)
    );

    acid_unlock u_unlock (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .crtc_select_wr (crtc_select_wr),
        .select_byte    (select_byte),
        .unlocked       (acid_unlocked)
    );

endmodule

`default_nettype wire

// File: acid_unlock.sv
`timescale 1ns/1ps
`default_nettype none

module acid_unlock (
    input  wire logic                clk_sys,
    input  wire logic                reset,
    input  wire logic                crtc_select_wr,
    input  wire asic_bus_pkg::data_t select_byte,
    output logic                     unlocked
);

    logic [$clog2(video_regs_pkg::ACID_SEQ_LEN)-1:0] seq_pos;  // Next expected byte
    logic                                            seq_match;

    assign seq_match = (select_byte == video_regs_pkg::ACID_SEQ[seq_pos]);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            seq_pos  <= '0;
            unlocked <= 1'b0;
        end else if (crtc_select_wr && !unlocked) begin
            if (!seq_match) begin
                seq_pos <= '0;  // Any wrong byte starts over
            end else if (seq_pos == video_regs_pkg::ACID_SEQ_LEN - 1) begin
                unlocked <= 1'b1;  // 16th match
            end else begin
                seq_pos <= seq_pos + 1'b1;
            end
        end
    end

    // Sticky until reset
    a_unlock_sticky: assert property (
        @(posedge clk_sys) disable iff (reset)
        unlocked |=> unlocked
    );

endmodule

`default_nettype wire

// File: crtc_regs.sv
`timescale 1ns/1ps
`default_nettype none

module crtc_regs (
    input  wire logic                   clk_sys,
    input  wire logic                   reset,
    reg_write_if.sink                   wr,
    input  wire logic                   unlocked,
    output logic                        crtc_select_wr,
    output asic_bus_pkg::data_t         select_byte,
    output video_regs_pkg::crtc_index_t crtc_reg_select,
    output asic_bus_pkg::data_t         selected_data
);

    asic_bus_pkg::data_t crtc_file [video_regs_pkg::NUM_CRTC_REGS];
    logic                write_allowed;

    // Upper registers only open after the unlock sequence
    assign write_allowed = (crtc_reg_select < video_regs_pkg::NUM_STD_CRTC) || unlocked;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            crtc_reg_select <= '0;
            crtc_select_wr  <= 1'b0;
            for (int i = 0; i < video_regs_pkg::NUM_CRTC_REGS; i++) begin
                crtc_file[i] <= '0;
            end
        end else begin
            crtc_select_wr <= 1'b0;
            if (wr.wr_strobe && wr.port == asic_bus_pkg::PORT_CRTC_SELECT) begin
                crtc_reg_select <= wr.data[$bits(video_regs_pkg::crtc_index_t)-1:0];
                crtc_select_wr  <= 1'b1;  // Full byte goes on to the unlock tracker
            end
            if (wr.wr_strobe && wr.port == asic_bus_pkg::PORT_CRTC_DATA && write_allowed) begin
                crtc_file[crtc_reg_select] <= wr.data;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (wr.wr_strobe && wr.port == asic_bus_pkg::PORT_CRTC_SELECT) begin
            select_byte <= wr.data;
        end
    end

    assign selected_data = crtc_file[crtc_reg_select];

    // Locked registers hold their value
    for (genvar i = video_regs_pkg::NUM_STD_CRTC; i < video_regs_pkg::NUM_CRTC_REGS; i++) begin
        : g_lock_check
        a_locked_stable: assert property (
            @(posedge clk_sys) disable iff (reset)
            !$stable(crtc_file[i]) |-> ($past(unlocked) || $past(reset))
        );
    end

endmodule

`default_nettype wire

// File: gate_array_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gate_array_regs (
    input  wire logic            clk_sys,
    input  wire logic            reset,
    reg_write_if.sink            wr,
    output video_regs_pkg::pen_t current_pen,
    output video_regs_pkg::ink_t pen_ink,
    output asic_bus_pkg::data_t  ram_config,
    output asic_bus_pkg::data_t  mrer,
    output asic_bus_pkg::data_t  rom_select
);

    typedef enum logic [2:0] {
        CMD_IGNORE,
        CMD_PEN_SELECT,
        CMD_INK_WRITE,
        CMD_RAM_CONFIG,
        CMD_MRER,
        CMD_PAGING_MRER
    } ga_cmd_e;

    ga_cmd_e              cmd;
    video_regs_pkg::ink_t ink_table [video_regs_pkg::NUM_PENS];

    // Classify the gate array write
    always_comb begin
        cmd = CMD_IGNORE;
        if (wr.wr_strobe && wr.port == asic_bus_pkg::PORT_GATE_ARRAY) begin
            if (wr.offset[7:4] == 4'h0 || wr.offset == 8'h10) begin
                cmd = (wr.data[7:6] == 2'b00) ? CMD_PEN_SELECT : CMD_INK_WRITE;
            end else if (wr.offset[7:3] == asic_bus_pkg::RAM_CONFIG_BASE[7:3]) begin
                cmd = CMD_RAM_CONFIG;
            end else if (wr.offset == asic_bus_pkg::MRER_OFFSET) begin
                cmd = CMD_MRER;
            end else if (wr.offset == asic_bus_pkg::PAGING_OFFSET && wr.data[7]) begin
                cmd = CMD_PAGING_MRER;  // Paging off leaves MRER alone
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            current_pen <= '0;
            ram_config  <= '0;
            mrer        <= '0;
            rom_select  <= '0;
            for (int i = 0; i < video_regs_pkg::NUM_PENS; i++) begin
                ink_table[i] <= '0;
            end
        end else begin
            case (cmd)
                CMD_PEN_SELECT:  current_pen <= wr.data[4:0];
                CMD_INK_WRITE:   ink_table[current_pen] <= wr.data[4:0];
                CMD_RAM_CONFIG:  ram_config <= wr.offset;  // Config is the offset itself
                CMD_MRER,
                CMD_PAGING_MRER: mrer <= wr.data;
                default: ;
            endcase
            if (wr.wr_strobe && wr.port == asic_bus_pkg::PORT_ROM_SELECT) begin
                rom_select <= wr.data;
            end
        end
    end

    assign pen_ink = ink_table[current_pen];  // Ink of the selected pen

endmodule

`default_nettype wire

// File: cpu_bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_decoder (
    input  wire logic                clk_sys,
    input  wire logic                reset,
    input  wire asic_bus_pkg::addr_t cpu_addr,
    input  wire asic_bus_pkg::data_t cpu_data_in,
    input  wire logic                cpu_wr,
    input  wire logic                cpu_rd,
    input  wire asic_bus_pkg::data_t selected_data,
    reg_write_if.source              wr,
    output asic_bus_pkg::data_t      rd_data,
    output logic                     rd_valid
);

    logic                cpu_wr_prev;
    logic                wr_edge;
    asic_bus_pkg::port_e port_dec;

    assign wr_edge = cpu_wr && !cpu_wr_prev;  // Only the rising edge writes

    always_comb begin
        port_dec = asic_bus_pkg::PORT_NONE;
        if (cpu_addr[15:8] == asic_bus_pkg::GA_PORT_HI) begin
            port_dec = asic_bus_pkg::PORT_GATE_ARRAY;
        end else if (cpu_addr == asic_bus_pkg::ROM_SELECT_ADDR) begin
            port_dec = asic_bus_pkg::PORT_ROM_SELECT;
        end else if (cpu_addr == asic_bus_pkg::CRTC_SELECT_ADDR) begin
            port_dec = asic_bus_pkg::PORT_CRTC_SELECT;
        end else if (cpu_addr == asic_bus_pkg::CRTC_DATA_ADDR) begin
            port_dec = asic_bus_pkg::PORT_CRTC_DATA;
        end
    end

    // Write path control
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cpu_wr_prev  <= 1'b0;
            wr.wr_strobe <= 1'b0;
        end else begin
            cpu_wr_prev  <= cpu_wr;
            wr.wr_strobe <= wr_edge && (port_dec != asic_bus_pkg::PORT_NONE);
        end
    end

    // Write payload, only meaningful alongside the strobe
    always_ff @(posedge clk_sys) begin
        wr.port   <= port_dec;
        wr.offset <= cpu_addr[7:0];
        wr.data   <= cpu_data_in;
    end

    // Read path, one result per cycle of cpu_rd on BF00
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rd_valid <= 1'b0;
            rd_data  <= '0;
        end else begin
            rd_valid <= cpu_rd && (cpu_addr == asic_bus_pkg::CRTC_READ_ADDR);
            if (cpu_rd && (cpu_addr == asic_bus_pkg::CRTC_READ_ADDR)) begin
                rd_data <= selected_data;
            end
        end
    end

    // A held strobe would write the same register twice
    a_single_strobe: assert property (
        @(posedge clk_sys) disable iff (reset)
        wr.wr_strobe |=> !wr.wr_strobe
    );

endmodule

`default_nettype wire

// File: reg_write_if.sv
`timescale 1ns/1ps
`default_nettype none

// One decoded register write, valid while wr_strobe is high
interface reg_write_if;

    logic                      wr_strobe;  // Single-cycle pulse per CPU write
    asic_bus_pkg::port_e       port;
    asic_bus_pkg::data_t       offset;     // Low address byte
    asic_bus_pkg::data_t       data;

    modport source (
        output wr_strobe,
        output port,
        output offset,
        output data
    );

    modport sink (
        input wr_strobe,
        input port,
        input offset,
        input data
    );

endinterface

`default_nettype wire

// File: video_regs_pkg.sv
`default_nettype none

package video_regs_pkg;

    localparam int NUM_PENS      = 32;
    localparam int NUM_CRTC_REGS = 32;
    localparam int NUM_STD_CRTC  = 16;  // Writable without the unlock sequence
    localparam int INK_W         = 5;

    typedef logic [$clog2(NUM_PENS)-1:0]      pen_t;
    typedef logic [INK_W-1:0]                 ink_t;
    typedef logic [$clog2(NUM_CRTC_REGS)-1:0] crtc_index_t;

    // Select-port bytes that open the upper CRTC registers
    localparam int ACID_SEQ_LEN = 16;

    localparam logic [7:0] ACID_SEQ [0:ACID_SEQ_LEN-1] = '{
        8'haa, 8'h00, 8'hff, 8'h77,
        8'hb3, 8'h51, 8'ha8, 8'hd4,
        8'h62, 8'h39, 8'h9c, 8'h46,
        8'h2b, 8'h15, 8'h8a, 8'hcd
    };

endpackage

`default_nettype wire

// File: asic_bus_pkg.sv
`default_nettype none

package asic_bus_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;  // CPU address
    typedef logic [DATA_W-1:0] data_t;  // CPU data byte

    // Decoded write targets
    typedef enum logic [2:0] {
        PORT_NONE,
        PORT_GATE_ARRAY,   // 7Fxx
        PORT_ROM_SELECT,   // DF00
        PORT_CRTC_SELECT,  // BC00
        PORT_CRTC_DATA     // BD00
    } port_e;

    // CPU I/O port map
    localparam data_t GA_PORT_HI       = 8'h7F;  // High byte only, low byte is the offset
    localparam addr_t ROM_SELECT_ADDR  = 16'hDF00;
    localparam addr_t CRTC_SELECT_ADDR = 16'hBC00;
    localparam addr_t CRTC_DATA_ADDR   = 16'hBD00;
    localparam addr_t CRTC_READ_ADDR   = 16'hBF00;  // Returns the selected CRTC register

    // Gate array offsets within 7Fxx
    localparam data_t RAM_CONFIG_BASE = 8'hC0;  // C0 to C7
    localparam data_t MRER_OFFSET     = 8'h89;
    localparam data_t PAGING_OFFSET   = 8'hB8;  // Only acts with data bit 7 set

endpackage

`default_nettype wire
